/* saturn_macros.svh */
// Saturn bus front end sizing macros
// Shared by the packages, the RTL and the testbench

`ifndef SATURN_MACROS_SVH
`define SATURN_MACROS_SVH

// Program list depth as log2, 32 entries
`define SATURN_LIST_AW 5

// Nibbles per address word (20-bit addresses)
`define SATURN_ADDR_NIBBLES 5

// Longest store burst in nibbles
`define SATURN_MAX_STORE 4

`endif

/* saturn_bus_pkg.sv */
// Bus-side types for the Saturn nibble bus
// Phases, command codes and the 5-bit program word

package saturn_bus_pkg;

    // One-hot bus phase, rotates P0 -> P3
    typedef enum logic [3:0] {
        PH_SEND  = 4'b0001,  // Put command/data or read strobe on the bus
        PH_LOWER = 4'b0010,  // Drop the bus strobe
        PH_READ  = 4'b0100,  // Sample read data, settle busy
        PH_IDLE  = 4'b1000
    } bus_phase_t;

    // Command nibbles understood by the memory side
    typedef enum logic [3:0] {
        CMD_PC_READ  = 4'h0,
        CMD_DP_WRITE = 4'h1,
        CMD_DP_READ  = 4'h2,
        CMD_LOAD_PC  = 4'h4,
        CMD_LOAD_DP  = 4'h5
    } bus_cmd_e;

    // Payload nibble, meaning set by is_cmd
    typedef union packed {
        bus_cmd_e    cmd;   // Command view
        logic [3:0]  data;  // Raw nibble view
    } prog_nibble_u;

    // Bit 4 flags a command, bits 3:0 carry the nibble
    typedef struct packed {
        logic         is_cmd;
        prog_nibble_u nib;
    } prog_word_t;

    function automatic prog_word_t cmd_word(input bus_cmd_e cmd);
        prog_word_t w;
        w.is_cmd  = 1'b1;
        w.nib.cmd = cmd;
        return w;
    endfunction

    function automatic prog_word_t data_word(input logic [3:0] nibble);
        prog_word_t w;
        w.is_cmd   = 1'b0;
        w.nib.data = nibble;
        return w;
    endfunction

endpackage

/* saturn_req_pkg.sv */
// Request-side types for the Saturn bus front end
// Kind of memory request and the request bundle

`include "saturn_macros.svh"

package saturn_req_pkg;

    // What the request asks the bus to do
    typedef enum logic [1:0] {
        REQ_JUMP  = 2'd0,  // New PC, start fetching
        REQ_STORE = 2'd1,  // Write 1..4 nibbles at addr
        REQ_FETCH = 2'd2   // Point DP at addr and read
    } req_kind_e;

    localparam int ADDR_W = 4 * `SATURN_ADDR_NIBBLES;
    localparam int DATA_W = 4 * `SATURN_MAX_STORE;
    localparam int LEN_W  = $clog2(`SATURN_MAX_STORE + 1);

    // Full request as seen on the strobe interface
    typedef struct packed {
        req_kind_e          kind;
        logic [ADDR_W-1:0]  addr;  // Sent low nibble first
        logic [DATA_W-1:0]  data;  // Store payload, low nibble first
        logic [LEN_W-1:0]   len;   // Store length, 1 to 4
    } bus_req_t;

endpackage

/* saturn_phase_gen.sv */
// Four-phase generator for the nibble bus
// One-hot ring advanced once per enabled clock

module saturn_phase_gen (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_clk_en,
    output saturn_bus_pkg::bus_phase_t o_phase
);

    import saturn_bus_pkg::*;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_phase <= PH_SEND;  // Start of a bus cycle
        end else if (i_clk_en) begin
            // Rotate left, P3 wraps to P0
            o_phase <= bus_phase_t'({o_phase[2:0], o_phase[3]});
        end
    end

endmodule

/* saturn_bus_sequencer.sv */
// Bus request sequencer
// Turns one JUMP/STORE/FETCH request into its list of bus program words

`include "saturn_macros.svh"

module saturn_bus_sequencer (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_req_valid,
    input  saturn_req_pkg::bus_req_t    i_req,
    output logic                        o_req_ready,
    input  logic                        i_list_full,
    output logic                        o_push,
    output saturn_bus_pkg::prog_word_t  o_word,
    output logic                        o_no_read
);

    import saturn_bus_pkg::*;
    import saturn_req_pkg::*;

    // Step numbering: 0 opening cmd, 1..5 address, 6 closing cmd, 7.. store data
    localparam int STEP_W = $clog2(`SATURN_ADDR_NIBBLES + `SATURN_MAX_STORE + 2);
    localparam logic [STEP_W-1:0] STEP_CLOSE = STEP_W'(`SATURN_ADDR_NIBBLES + 1);

    logic                  r_active;   // Words still to emit
    logic [STEP_W-1:0]     r_step;
    req_kind_e             r_kind;
    logic [LEN_W-1:0]      r_len;
    logic [ADDR_W-1:0]     r_addr;     // Shifts out low nibble first
    logic [DATA_W-1:0]     r_data;     // Same for store payload

    logic [STEP_W-1:0]     last_step;
    bus_cmd_e              open_cmd;
    bus_cmd_e              close_cmd;
    logic                  accept;

    assign o_req_ready = !r_active;
    assign accept      = i_req_valid && o_req_ready;
    assign o_push      = r_active && !i_list_full;  // Hold while list is full

    // Commands framing the address for each kind
    always_comb begin
        case (r_kind)
            REQ_JUMP: begin
                open_cmd  = CMD_LOAD_PC;
                close_cmd = CMD_PC_READ;
            end
            REQ_STORE: begin
                open_cmd  = CMD_LOAD_DP;
                close_cmd = CMD_DP_WRITE;
            end
            default: begin
                open_cmd  = CMD_LOAD_DP;
                close_cmd = CMD_DP_READ;
            end
        endcase
    end

    // Stores run past the closing command by their length
    assign last_step = (r_kind == REQ_STORE) ? STEP_CLOSE + STEP_W'(r_len) : STEP_CLOSE;

    always_comb begin
        if (r_step == '0)
            o_word = cmd_word(open_cmd);
        else if (r_step < STEP_CLOSE)
            o_word = data_word(r_addr[3:0]);  // Address nibble
        else if (r_step == STEP_CLOSE)
            o_word = cmd_word(close_cmd);
        else
            o_word = data_word(r_data[3:0]);  // Store nibble
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_active  <= 1'b0;
            r_step    <= '0;
            o_no_read <= 1'b1;  // No reads until a JUMP or FETCH
        end else if (accept) begin
            r_active  <= 1'b1;
            r_step    <= '0;
            o_no_read <= (i_req.kind == REQ_STORE);
        end else if (o_push) begin
            r_step <= r_step + 1'b1;
            if (r_step == last_step)
                r_active <= 1'b0;  // Last word pushed, ready again
        end
    end

    // Request payload and nibble shifters
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_kind <= i_req.kind;
            r_len  <= i_req.len;
            r_addr <= i_req.addr;
            r_data <= i_req.data;
        end else if (o_push) begin
            if (r_step != '0 && r_step < STEP_CLOSE)
                r_addr <= r_addr >> 4;
            if (r_step > STEP_CLOSE)
                r_data <= r_data >> 4;
        end
    end

endmodule

/* saturn_bus_prog_list.sv */
// Circular program list between the sequencer and the bus controller
// Written by push, drained by pop, head read without latency

`include "saturn_macros.svh"

module saturn_bus_prog_list #(
    parameter int AW = `SATURN_LIST_AW
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_push,
    input  saturn_bus_pkg::prog_word_t  i_word,
    input  logic                        i_pop,
    output saturn_bus_pkg::prog_word_t  o_head,
    output logic                        o_more,
    output logic                        o_full
);

    import saturn_bus_pkg::*;

    localparam int DEPTH = 2 ** AW;

    prog_word_t        mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW-1:0]     wr_next;

    assign wr_next = wr_ptr + 1'b1;
    assign o_more  = (wr_ptr != rd_ptr);   // Words left to send
    assign o_full  = (wr_next == rd_ptr);  // One slot kept free
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push && !o_full)
                wr_ptr <= wr_next;
            if (i_pop && o_more)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage has no reset
    always_ff @(posedge i_clk) begin
        if (i_push && !o_full)
            mem[wr_ptr] <= i_word;
    end

endmodule

/* saturn_bus_controller.sv */
// Four-phase nibble bus master
// Sends queued program words, runs read cycles when idle, tracks busy

module saturn_bus_controller (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_clk_en,
    input  saturn_bus_pkg::bus_phase_t  i_phase,
    input  logic                        i_more,
    input  saturn_bus_pkg::prog_word_t  i_head,
    output logic                        o_pop,
    input  logic                        i_no_read,
    output logic                        o_bus_clk_en,
    output logic                        o_bus_is_data,
    output logic [3:0]                  o_bus_nibble_out,
    input  logic [3:0]                  i_bus_nibble_in,
    output logic [3:0]                  o_read_nibble,
    output logic                        o_read_valid,
    output logic                        o_bus_busy
);

    import saturn_bus_pkg::*;

    logic send_word;     // P0 with a queued word
    logic start_read;    // P0, nothing queued, reads on
    logic capture;
    logic read_pending;  // A read strobe went out this cycle

    assign send_word  = i_clk_en && (i_phase == PH_SEND) && i_more;
    assign start_read = i_clk_en && (i_phase == PH_SEND) && !i_more && !i_no_read;
    assign capture    = i_clk_en && (i_phase == PH_READ) && !o_bus_busy && read_pending;
    assign o_pop      = send_word;  // Word leaves the list as it goes out

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus_clk_en <= 1'b0;
            o_bus_busy   <= 1'b1;
            read_pending <= 1'b0;
            o_read_valid <= 1'b0;
        end else begin
            o_read_valid <= capture;  // One clock after the sample
            if (i_clk_en) begin
                case (i_phase)
                    PH_SEND: begin
                        if (send_word) begin
                            o_bus_clk_en <= 1'b1;
                            o_bus_busy   <= 1'b1;
                        end else if (start_read) begin
                            o_bus_clk_en <= 1'b1;
                            read_pending <= 1'b1;
                        end
                    end
                    PH_LOWER: o_bus_clk_en <= 1'b0;  // Strobe lasts one enabled clock
                    PH_READ: begin
                        read_pending <= 1'b0;
                        if (!i_more && o_bus_busy)
                            o_bus_busy <= 1'b0;  // Whole program is out
                    end
                    default: ;  // P3 has no bus action
                endcase
            end
        end
    end

    // Bus payload, meaningful only while the strobe is up
    always_ff @(posedge i_clk) begin
        if (send_word) begin
            o_bus_is_data    <= !i_head.is_cmd;
            o_bus_nibble_out <= i_head.nib.data;
        end else if (start_read) begin
            o_bus_is_data    <= 1'b1;
        end
        if (capture)
            o_read_nibble <= i_bus_nibble_in;
    end

endmodule

/* saturn_bus_top.sv */
// Saturn nibble bus front end
// Sequencer feeds the program list, controller drains it onto the bus

`include "saturn_macros.svh"

module saturn_bus_top (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_clk_en,
    input  logic                      i_req_valid,
    input  saturn_req_pkg::bus_req_t  i_req,
    output logic                      o_req_ready,
    output logic                      o_bus_clk_en,
    output logic                      o_bus_is_data,
    output logic [3:0]                o_bus_nibble_out,
    input  logic [3:0]                i_bus_nibble_in,
    output logic [3:0]                o_read_nibble,
    output logic                      o_read_valid,
    output logic                      o_bus_busy
);

    import saturn_bus_pkg::*;

    bus_phase_t  phase;
    logic        push;
    prog_word_t  push_word;
    logic        list_full;
    logic        pop;
    prog_word_t  head_word;
    logic        more;
    logic        no_read;

    saturn_phase_gen u_phase_gen (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clk_en (i_clk_en),
        .o_phase  (phase)
    );

    saturn_bus_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .i_list_full (list_full),
        .o_push      (push),
        .o_word      (push_word),
        .o_no_read   (no_read)
    );

    saturn_bus_prog_list #(
        .AW (`SATURN_LIST_AW)
    ) u_prog_list (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_push  (push),
        .i_word  (push_word),
        .i_pop   (pop),
        .o_head  (head_word),
        .o_more  (more),
        .o_full  (list_full)
    );

    saturn_bus_controller u_controller (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clk_en         (i_clk_en),
        .i_phase          (phase),
        .i_more           (more),
        .i_head           (head_word),
        .o_pop            (pop),
        .i_no_read        (no_read),
        .o_bus_clk_en     (o_bus_clk_en),
        .o_bus_is_data    (o_bus_is_data),
        .o_bus_nibble_out (o_bus_nibble_out),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .o_read_nibble    (o_read_nibble),
        .o_read_valid     (o_read_valid),
        .o_bus_busy       (o_bus_busy)
    );

endmodule

/* saturn_bus_assertions.sv */
// Protocol checks on the four-phase bus controller
// Strobe length, pop against list state, read return against sends

module saturn_bus_assertions (
    input logic i_clk,
    input logic i_reset,
    input logic i_clk_en,
    input logic i_more,
    input logic o_pop,
    input logic o_bus_clk_en,
    input logic o_read_valid
);

    // Strobe set in P0 must drop on the P1 enabled clock
    a_strobe_one_phase: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_clk_en && o_bus_clk_en) |=> !o_bus_clk_en)
        else $error("bus strobe held across two enabled clocks");

    // A pop needs a queued word and the previous strobe already dropped
    a_pop_has_word: assert property (@(posedge i_clk) disable iff (i_reset)
        o_pop |-> (i_more && !o_bus_clk_en))
        else $error("pop with an empty program list or the bus strobe still up");

    // Read data lands in P3, sends only happen in P0
    a_valid_not_on_send: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_read_valid && o_pop))
        else $error("read valid overlaps a word send");

endmodule

/* tb_saturn_bus.sv */
// Directed testbench for the Saturn nibble bus front end
// Bus monitor, phase model and expected word lists per request

`include "saturn_macros.svh"

module tb_saturn_bus;

    import saturn_bus_pkg::*;
    import saturn_req_pkg::*;

    logic        i_clk;
    logic        i_reset;
    logic        i_clk_en = 1'b1;
    logic        i_req_valid;
    bus_req_t    i_req;
    logic [3:0]  i_bus_nibble_in;
    logic        o_req_ready;
    logic        o_bus_clk_en;
    logic        o_bus_is_data;
    logic [3:0]  o_bus_nibble_out;
    logic [3:0]  o_read_nibble;
    logic        o_read_valid;
    logic        o_bus_busy;

    logic [1:0]  ph_model;       // Phase index, P0 after reset
    logic        mon_prev;       // Strobe level at the previous edge
    bit          rand_clk_en;    // Test 5 toggles the bus enable
    prog_word_t  seen_q[$];      // Every strobe seen on the bus
    prog_word_t  exp_q[$];
    int          word_errs;
    int          nib_errs;
    int          level_errs;
    int          other_errs;

    saturn_bus_top uut (.*);

    bind saturn_bus_controller saturn_bus_assertions u_assertions (
        .i_clk(i_clk), .i_reset(i_reset), .i_clk_en(i_clk_en), .i_more(i_more),
        .o_pop(o_pop), .o_bus_clk_en(o_bus_clk_en), .o_read_valid(o_read_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Phase mirror and bus monitor, one word per rising strobe
    always @(posedge i_clk) begin
        if (i_reset) begin
            ph_model <= 2'd0;
            mon_prev <= 1'b0;
        end else begin
            if (i_clk_en)
                ph_model <= ph_model + 2'd1;
            mon_prev <= o_bus_clk_en;
            if (o_bus_clk_en && !mon_prev)
                seen_q.push_back(prog_word_t'({!o_bus_is_data, o_bus_nibble_out}));
        end
    end

    always @(negedge i_clk)
        i_clk_en <= rand_clk_en ? 1'($urandom_range(1, 0)) : 1'b1;

    task automatic check_word(input string name, input prog_word_t got, input prog_word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            nib_errs++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic verify_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            level_errs++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        other_errs++;
        $display("Failure: %s", msg);
    endtask

    function automatic bus_req_t rand_req(input req_kind_e kind);
        bus_req_t r;
        r.kind = kind;
        r.addr = ADDR_W'($urandom);
        r.data = DATA_W'($urandom);
        r.len  = LEN_W'($urandom_range(`SATURN_MAX_STORE, 1));
        return r;
    endfunction

    // Opening command, address low nibble first, closing command, store data
    task automatic expect_request(input bus_req_t r);
        bus_cmd_e open_c;
        bus_cmd_e close_c;
        open_c  = (r.kind == REQ_JUMP) ? CMD_LOAD_PC : CMD_LOAD_DP;
        close_c = (r.kind == REQ_JUMP) ? CMD_PC_READ :
                  (r.kind == REQ_STORE) ? CMD_DP_WRITE : CMD_DP_READ;
        exp_q.push_back(prog_word_t'({1'b1, open_c}));
        for (int i = 0; i < `SATURN_ADDR_NIBBLES; i++)
            exp_q.push_back(prog_word_t'({1'b0, r.addr[4*i +: 4]}));
        exp_q.push_back(prog_word_t'({1'b1, close_c}));
        if (r.kind == REQ_STORE)
            for (int i = 0; i < int'(r.len); i++)
                exp_q.push_back(prog_word_t'({1'b0, r.data[4*i +: 4]}));
    endtask

    // A first request goes out in P2, so no read strobe lands ahead of its words
    task automatic send_request(input bus_req_t r, input bit first);
        int t = 0;
        while ((!o_req_ready || (first && ph_model != 2'd2)) && t < 400) begin
            @(negedge i_clk);
            t++;
        end
        if (!o_req_ready)
            report_fault("request side never became ready");
        if (first) begin
            seen_q.delete();
            exp_q.delete();
        end
        i_req_valid = 1'b1;
        i_req       = r;
        expect_request(r);
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    task automatic wait_words(input int n);
        int t = 0;
        while (seen_q.size() < n && t < 1000) begin
            @(negedge i_clk);
            t++;
        end
        if (seen_q.size() < n)
            report_fault($sformatf("only %0d of %0d bus words arrived", seen_q.size(), n));
    endtask

    task automatic check_stream(input int n);
        for (int i = 0; i < n && i < seen_q.size(); i++)
            check_word($sformatf("o_bus_is_data/o_bus_nibble_out word %0d", i),
                       seen_q[i], exp_q[i]);
    endtask

    task automatic after_reset();
        verify_level("o_bus_clk_en", o_bus_clk_en, 1'b0);
        verify_level("o_read_valid", o_read_valid, 1'b0);
        verify_level("o_req_ready", o_req_ready, 1'b1);
        verify_level("o_bus_busy", o_bus_busy, 1'b1);
        repeat (40) begin
            @(negedge i_clk);
            if (o_read_valid)
                report_fault("read data returned while reads are disabled");
        end
        if (seen_q.size() != 0)
            report_fault("bus strobe seen before any request");
    endtask

    task automatic jump_stream();
        send_request(rand_req(REQ_JUMP), 1'b1);
        wait_words(exp_q.size() + 3);  // Room for a few reads
        check_stream(exp_q.size());
        for (int i = exp_q.size(); i < seen_q.size(); i++)
            if (seen_q[i].is_cmd)
                report_fault("command strobe where only reads belong");
    endtask

    task automatic store_stream();
        int t = 0;
        send_request(rand_req(REQ_STORE), 1'b1);
        wait_words(exp_q.size());
        check_stream(exp_q.size());
        while (o_bus_busy && t < 100) begin
            @(negedge i_clk);
            t++;
        end
        if (o_bus_busy)
            report_fault("o_bus_busy stayed high after the store");
        repeat (40) @(negedge i_clk);
        if (seen_q.size() != exp_q.size())
            report_fault("bus strobes kept coming after the store");
    endtask

    // Past DP_READ every strobe is a read, answered with a fresh nibble
    task automatic fetch_reads();
        logic [3:0] nib;
        logic [3:0] exp_nib[$];
        logic       prev = 1'b0;
        int         strobes = 0;
        int         checked = 0;
        int         t = 0;
        send_request(rand_req(REQ_FETCH), 1'b1);
        while (checked < 4 && t < 600) begin
            @(negedge i_clk);
            t++;
            if (o_bus_clk_en && !prev) begin
                strobes++;
                if (strobes > exp_q.size()) begin
                    nib = 4'($urandom);
                    i_bus_nibble_in = nib;
                    exp_nib.push_back(nib);
                end
            end
            prev = o_bus_clk_en;
            if (o_read_valid) begin
                if (exp_nib.size() == 0) begin
                    report_fault("read data without a read cycle");
                end else begin
                    compare_nibble("o_read_nibble", o_read_nibble, exp_nib.pop_front());
                    checked++;
                end
            end
        end
        if (checked < 4)
            report_fault("read data did not come back");
        check_stream(exp_q.size());
    endtask

    task automatic back_to_back();
        bus_req_t jr;
        bus_req_t sr;
        bus_req_t fr;
        jr = rand_req(REQ_JUMP);
        sr = rand_req(REQ_STORE);
        fr = rand_req(REQ_FETCH);
        @(posedge i_clk);
        rand_clk_en = 1'b1;
        @(negedge i_clk);
        send_request(jr, 1'b1);
        send_request(sr, 1'b0);
        send_request(fr, 1'b0);
        wait_words(exp_q.size());
        check_stream(exp_q.size());
        @(posedge i_clk);
        rand_clk_en = 1'b0;
        @(negedge i_clk);
    endtask

    initial begin
        void'($urandom(32'hdedd_86c2));
        i_reset         = 1'b1;
        i_req_valid     = 1'b0;
        i_req           = '0;
        i_bus_nibble_in = 4'h0;
        rand_clk_en     = 1'b0;
        word_errs       = 0;
        nib_errs        = 0;
        level_errs      = 0;
        other_errs      = 0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        after_reset();
        jump_stream();
        store_stream();
        fetch_reads();
        back_to_back();
        $display("errors: bus words %0d, read nibbles %0d, levels %0d, other %0d",
                 word_errs, nib_errs, level_errs, other_errs);
        if (word_errs + nib_errs + level_errs + other_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
saturn_bus_pkg.sv
saturn_req_pkg.sv
saturn_phase_gen.sv
saturn_bus_sequencer.sv
saturn_bus_prog_list.sv
saturn_bus_controller.sv
saturn_bus_top.sv
saturn_bus_assertions.sv
tb_saturn_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Saturn bus testbench with Verilator
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_saturn_bus -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
